// ==== fir_settings.svh ====
// Tap count, datapath widths, control block base address and register map macros
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// --------------------------------------------------
// Filter dimensions
// --------------------------------------------------
`define FIR_NUM_COEFFS 8
`define FIR_COEFF_W 16
`define FIR_SAMPLE_W 16
// 32-bit products plus log2(8) guard bits
`define FIR_ACC_W 35

// --------------------------------------------------
// Control port
// --------------------------------------------------
`define FIR_CTRL_ADDR_W 20
`define FIR_CTRL_DATA_W 32
`define FIR_BASE_ADDR 20'h00100
// Low address bits decoded inside the block
`define FIR_ADDR_W 4

// Register offsets
`define REG_NUM_COEFFS 4'h0
`define REG_LOAD_COEFF 4'h4
`define REG_LOAD_COEFF_LAST 4'h8
`define REG_STATUS 4'hC

`endif

// ==== fir_pkg.sv ====
// Coefficient, sample, I/Q word and control port handshake types
`include "fir_settings.svh"

package fir_pkg;

  // --------------------------------------------------
  // Datapath types
  // --------------------------------------------------

  // One signed Q15 coefficient
  typedef logic signed [`FIR_COEFF_W-1:0] coeff_t;

  // Full coefficient set, index 0 multiplies the newest sample
  typedef coeff_t [`FIR_NUM_COEFFS-1:0] coeff_bank_t;

  // One signed I or Q sample
  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;

  // I in the upper half, Q in the lower half
  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_parts_t;

  // Stream word, seen raw on the ports and split inside the core
  typedef union packed {
    logic [2*`FIR_SAMPLE_W-1:0] raw;
    iq_parts_t                  parts;
  } iq_word_u;

  // Register block to loader write request
  typedef struct packed {
    coeff_t coeff;
    logic   last;
  } coeff_req_t;

  // --------------------------------------------------
  // Control port
  // --------------------------------------------------
  typedef struct packed {
    logic                        wr;
    logic                        rd;
    logic [`FIR_CTRL_ADDR_W-1:0] addr;
    logic [`FIR_CTRL_DATA_W-1:0] data;
  } ctrl_req_t;

  typedef struct packed {
    logic                        ack;
    logic [`FIR_CTRL_DATA_W-1:0] data;
  } ctrl_resp_t;

endpackage

// ==== fir_ctrl_regs.sv ====
// Control port register block with address decode, coefficient write forwarding and read mux
`include "fir_settings.svh"

module fir_ctrl_regs (
  input  logic                clk,
  input  logic                rst,
  input  fir_pkg::ctrl_req_t  ctrl_req,
  output fir_pkg::ctrl_resp_t ctrl_resp,
  output fir_pkg::coeff_req_t coeff_req,
  output logic                coeff_valid,
  input  logic                coeff_ready,
  input  logic                reload_error,
  input  logic                filled
);

  localparam int BLK_W = `FIR_CTRL_ADDR_W - `FIR_ADDR_W;
  localparam logic [`FIR_CTRL_ADDR_W-1:0] BASE = `FIR_BASE_ADDR;

  logic [BLK_W-1:0]            block_addr;
  logic [`FIR_ADDR_W-1:0]      reg_addr;
  logic                        in_block;
  logic                        wr_coeff;
  logic                        wr_last;
  logic                        fast_ack;
  logic                        resp_ack;
  logic [`FIR_CTRL_DATA_W-1:0] resp_data;
  logic [`FIR_CTRL_DATA_W-1:0] rd_data;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  // Block part selects this instance, byte offset ignored
  assign block_addr = ctrl_req.addr[`FIR_CTRL_ADDR_W-1:`FIR_ADDR_W];
  assign reg_addr   = {ctrl_req.addr[`FIR_ADDR_W-1:2], 2'b00};
  assign in_block   = (block_addr == BASE[`FIR_CTRL_ADDR_W-1:`FIR_ADDR_W]);

  // Writes to either load register go through the loader
  assign wr_last  = in_block && ctrl_req.wr && (reg_addr == `REG_LOAD_COEFF_LAST);
  assign wr_coeff = wr_last ||
                    (in_block && ctrl_req.wr && (reg_addr == `REG_LOAD_COEFF));

  // Everything else in the block answers on the next cycle
  assign fast_ack = in_block && (ctrl_req.rd || (ctrl_req.wr && !wr_coeff));

  // Read mux
  always_comb begin
    case (reg_addr)
      `REG_NUM_COEFFS: rd_data = `FIR_CTRL_DATA_W'(`FIR_NUM_COEFFS);
      // Bit 1 filled, bit 0 sticky reload error
      `REG_STATUS:     rd_data = {{(`FIR_CTRL_DATA_W-2){1'b0}}, filled, reload_error};
      default:         rd_data = '0;
    endcase
  end

  // --------------------------------------------------
  // Handshake state
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_ack    <= 1'b0;
      coeff_valid <= 1'b0;
    end else begin
      // Coefficient write acks only once the loader took the word
      resp_ack <= fast_ack || (coeff_valid && coeff_ready);
      if (coeff_valid && coeff_ready) begin
        coeff_valid <= 1'b0;
      end
      if (wr_coeff) begin
        coeff_valid <= 1'b1;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (wr_coeff) begin
      coeff_req.coeff <= ctrl_req.data[`FIR_COEFF_W-1:0];
      coeff_req.last  <= wr_last;
    end
    // Zero unless a read is being answered
    resp_data <= (in_block && ctrl_req.rd) ? rd_data : '0;
  end

  assign ctrl_resp.ack  = resp_ack;
  assign ctrl_resp.data = resp_data;

endmodule

// ==== fir_coeff_loader.sv ====
// Coefficient reload FSM with shadow bank, active bank commit and malformed load detection
`include "fir_settings.svh"

module fir_coeff_loader (
  input  logic                 clk,
  input  logic                 rst,
  input  fir_pkg::coeff_req_t  coeff_req,
  input  logic                 coeff_valid,
  output logic                 coeff_ready,
  output fir_pkg::coeff_bank_t bank,
  output logic                 reload_error
);

  localparam int N = `FIR_NUM_COEFFS;
  // Counts up to N so an overlong load is still caught
  localparam int CNT_W = $clog2(N + 1);

  // Impulse, max positive value at tap 0
  localparam fir_pkg::coeff_bank_t IMPULSE =
    {{((N-1)*`FIR_COEFF_W){1'b0}}, 1'b0, {(`FIR_COEFF_W-1){1'b1}}};

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    COMMIT
  } state_t;

  state_t               state;
  logic [CNT_W-1:0]     count;
  logic                 commit_ok;
  logic                 accept;
  logic                 count_ok;
  fir_pkg::coeff_bank_t shadow;

  // Stall the register block during the commit cycle
  assign coeff_ready = (state != COMMIT);
  assign accept      = coeff_valid && coeff_ready;
  // Last word completes a full set only after N-1 plain words
  assign count_ok    = (count == CNT_W'(N - 1));

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      count        <= '0;
      commit_ok    <= 1'b0;
      reload_error <= 1'b0;
      bank         <= IMPULSE;
    end else begin
      case (state)
        IDLE, LOAD: begin
          if (accept && coeff_req.last) begin
            state     <= COMMIT;
            count     <= '0;
            commit_ok <= count_ok;
            if (!count_ok) begin
              reload_error <= 1'b1;
            end
          end else if (accept) begin
            state <= LOAD;
            if (count != CNT_W'(N)) begin
              count <= count + 1'b1;
            end
          end
        end
        COMMIT: begin
          // Bad loads leave the previous bank in place
          if (commit_ok) begin
            bank <= shadow;
          end
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift in from the top so the first word lands at tap 0
  always_ff @(posedge clk) begin
    if (accept) begin
      shadow <= {coeff_req.coeff, shadow[N-1:1]};
    end
  end

endmodule

// ==== fir_fill_counter.sv ====
// Saturating count of accepted samples and delay line filled flag
`include "fir_settings.svh"

module fir_fill_counter (
  input  logic clk,
  input  logic rst,
  input  logic taken,
  output logic filled
);

  localparam int N = `FIR_NUM_COEFFS;
  localparam int CNT_W = $clog2(N);

  logic [CNT_W-1:0] count;

  // --------------------------------------------------
  // Counter
  // --------------------------------------------------

  // Stops at N-1, filled rises together with the final count
  always_ff @(posedge clk) begin
    if (rst) begin
      count  <= '0;
      filled <= 1'b0;
    end else if (taken && !filled) begin
      count <= count + 1'b1;
      if (count == CNT_W'(N - 2)) begin
        filled <= 1'b1;
      end
    end
  end

endmodule

// ==== fir_channel.sv ====
// Single real FIR datapath with delay line, MAC, Q15 scaling and output register
`include "fir_settings.svh"

module fir_channel (
  input  logic                 clk,
  input  logic                 rst,
  input  fir_pkg::sample_t     in_sample,
  input  logic                 in_last,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  fir_pkg::coeff_bank_t bank,
  input  logic                 filled,
  output logic                 taken,
  output fir_pkg::sample_t     out_sample,
  output logic                 out_last,
  output logic                 out_valid,
  input  logic                 out_ready
);

  localparam int N = `FIR_NUM_COEFFS;
  // Q15 coefficients
  localparam int SHIFT = `FIR_COEFF_W - 1;

  // Previous N-1 samples, index 0 most recent
  fir_pkg::sample_t [N-2:0]     delay;
  // Newest sample plus history, one entry per tap
  fir_pkg::sample_t [N-1:0]     window;
  logic signed [`FIR_ACC_W-1:0] acc;
  fir_pkg::sample_t             y;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------

  // Accept when the output register is empty or draining
  assign in_ready = out_ready || !out_valid;
  assign taken    = in_valid && in_ready;

  // --------------------------------------------------
  // Multiply-accumulate
  // --------------------------------------------------
  assign window = {delay, in_sample};

  always_comb begin
    acc = '0;
    for (int k = 0; k < N; k++) begin
      // Operands sign extended to accumulator width
      acc = acc + $signed(bank[k]) * $signed(window[k]);
    end
  end

  // Arithmetic shift by 15 then keep the low 16 bits
  assign y = acc[SHIFT + `FIR_SAMPLE_W - 1:SHIFT];

  // --------------------------------------------------
  // Delay line and output register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      delay     <= '0;
    end else begin
      if (taken) begin
        // Blanked until the history is complete
        out_valid <= filled;
        delay     <= window[N-2:0];
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Result and tlast follow the accepted sample
  always_ff @(posedge clk) begin
    if (taken) begin
      out_sample <= y;
      out_last   <= in_last;
    end
  end

endmodule

// ==== fir_iq_core.sv ====
// Complex FIR top with register block, coefficient loader, fill counter and I/Q channels

module fir_iq_core (
  input  logic                clk,
  input  logic                rst,
  input  fir_pkg::ctrl_req_t  ctrl_req,
  output fir_pkg::ctrl_resp_t ctrl_resp,
  input  fir_pkg::iq_word_u   s_tdata,
  input  logic                s_tlast,
  input  logic                s_tvalid,
  output logic                s_tready,
  output fir_pkg::iq_word_u   m_tdata,
  output logic                m_tlast,
  output logic                m_tvalid,
  input  logic                m_tready
);

  fir_pkg::coeff_req_t  coeff_req;
  logic                 coeff_valid;
  logic                 coeff_ready;
  logic                 reload_error;
  fir_pkg::coeff_bank_t bank;
  logic                 filled;
  logic                 taken;
  fir_pkg::sample_t     out_i;
  fir_pkg::sample_t     out_q;

  // --------------------------------------------------
  // Control path
  // --------------------------------------------------
  fir_ctrl_regs regs_inst (
    .clk          (clk),
    .rst          (rst),
    .ctrl_req     (ctrl_req),
    .ctrl_resp    (ctrl_resp),
    .coeff_req    (coeff_req),
    .coeff_valid  (coeff_valid),
    .coeff_ready  (coeff_ready),
    .reload_error (reload_error),
    .filled       (filled)
  );

  fir_coeff_loader loader_inst (
    .clk          (clk),
    .rst          (rst),
    .coeff_req    (coeff_req),
    .coeff_valid  (coeff_valid),
    .coeff_ready  (coeff_ready),
    .bank         (bank),
    .reload_error (reload_error)
  );

  // Driven by I acceptance, Q is in lockstep
  fir_fill_counter fill_inst (
    .clk    (clk),
    .rst    (rst),
    .taken  (taken),
    .filled (filled)
  );

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------

  // I channel owns the stream handshake
  fir_channel chan_i (
    .clk        (clk),
    .rst        (rst),
    .in_sample  (s_tdata.parts.i),
    .in_last    (s_tlast),
    .in_valid   (s_tvalid),
    .in_ready   (s_tready),
    .bank       (bank),
    .filled     (filled),
    .taken      (taken),
    .out_sample (out_i),
    .out_last   (m_tlast),
    .out_valid  (m_tvalid),
    .out_ready  (m_tready)
  );

  // Same handshake inputs so its state mirrors chan_i
  fir_channel chan_q (
    .clk        (clk),
    .rst        (rst),
    .in_sample  (s_tdata.parts.q),
    .in_last    (s_tlast),
    .in_valid   (s_tvalid),
    .in_ready   (),
    .bank       (bank),
    .filled     (filled),
    .taken      (),
    .out_sample (out_q),
    .out_last   (),
    .out_valid  (),
    .out_ready  (m_tready)
  );

  assign m_tdata.parts = '{i: out_i, q: out_q};

endmodule

// ==== tb_fir_iq_core.sv ====
// Testbench for the complex FIR core with stimulus table, reference model, compare tasks, watchdog
`include "fir_settings.svh"

module tb_fir_iq_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = `FIR_NUM_COEFFS;
  localparam int SHIFT = `FIR_COEFF_W - 1;
  localparam logic [`FIR_CTRL_ADDR_W-1:0] BASE = `FIR_BASE_ADDR;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_BURST} op_t;

  // One table row, burst rows use only len
  typedef struct packed {
    op_t                         op;
    logic [`FIR_CTRL_ADDR_W-1:0] addr;
    logic [`FIR_CTRL_DATA_W-1:0] data;
    logic [`FIR_CTRL_DATA_W-1:0] exp_rd;
    logic [15:0]                 len;
  } entry_t;

  typedef struct packed {
    fir_pkg::iq_word_u word;
    logic              last;
  } exp_out_t;

  logic                clk;
  logic                rst;
  fir_pkg::ctrl_req_t  ctrl_req;
  fir_pkg::ctrl_resp_t ctrl_resp;
  fir_pkg::iq_word_u   s_tdata;
  logic                s_tlast;
  logic                s_tvalid;
  logic                s_tready;
  fir_pkg::iq_word_u   m_tdata;
  logic                m_tlast;
  logic                m_tvalid;
  logic                m_tready;

  // Reference model state
  fir_pkg::coeff_bank_t m_bank;
  fir_pkg::coeff_t      shadow_q[$];
  int                   fill_cnt;
  fir_pkg::sample_t     hist_i [N];
  fir_pkg::sample_t     hist_q [N];
  exp_out_t             exp_q[$];
  entry_t               stim_q[$];
  int                   limit = 0;

  fir_iq_core fir_iq_core_inst (
    .clk       (clk),
    .rst       (rst),
    .ctrl_req  (ctrl_req),
    .ctrl_resp (ctrl_resp),
    .s_tdata   (s_tdata),
    .s_tlast   (s_tlast),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .m_tdata   (m_tdata),
    .m_tlast   (m_tlast),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Error handling and compare tasks
  // --------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_resp(input fir_pkg::ctrl_resp_t exp, input fir_pkg::ctrl_resp_t got);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail ctrl_resp exp=%h got=%h", exp, got));
    end
  endtask

  task automatic check_sample(input fir_pkg::iq_word_u exp, input fir_pkg::iq_word_u got);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail m_tdata exp=I %h Q %h got=I %h Q %h",
                              exp.parts.i, exp.parts.q, got.parts.i, got.parts.q));
    end
  endtask

  task automatic check_last(input logic exp, input logic got);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail m_tlast exp=%h got=%h", exp, got));
    end
  endtask

  task automatic check_ack_delay(input int exp, input int got);
    if (got != exp) begin
      stop_on_error($sformatf("Fail ack_delay exp=%h got=%h", exp, got));
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Sum of products, shift by 15, keep 16 bits
  function automatic fir_pkg::sample_t fir_ref(input fir_pkg::coeff_bank_t b,
                                               input fir_pkg::sample_t h [N]);
    longint acc;
    acc = 0;
    for (int k = 0; k < N; k++) begin
      acc += longint'(b[k]) * longint'(h[k]);
    end
    return fir_pkg::sample_t'(acc >>> SHIFT);
  endfunction

  task automatic model_sample(input fir_pkg::iq_word_u w, input logic last);
    exp_out_t e;
    for (int k = N - 1; k > 0; k--) begin
      hist_i[k] = hist_i[k-1];
      hist_q[k] = hist_q[k-1];
    end
    hist_i[0] = w.parts.i;
    hist_q[0] = w.parts.q;
    // Blanked until N-1 samples were taken
    if (fill_cnt == N - 1) begin
      e.word.parts.i = fir_ref(m_bank, hist_i);
      e.word.parts.q = fir_ref(m_bank, hist_q);
      e.last = last;
      exp_q.push_back(e);
    end else begin
      fill_cnt++;
    end
  endtask

  // First word lands at tap 0, last word at tap N-1
  task automatic model_write(input logic [`FIR_ADDR_W-1:0] off, input fir_pkg::coeff_t c);
    if (off == `REG_LOAD_COEFF) begin
      shadow_q.push_back(c);
    end else if (off == `REG_LOAD_COEFF_LAST) begin
      // Loads of the wrong length keep the old bank
      if (shadow_q.size() == N - 1) begin
        for (int k = 0; k < N - 1; k++) begin
          m_bank[k] = shadow_q[k];
        end
        m_bank[N-1] = c;
      end
      shadow_q.delete();
    end
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  function automatic logic [`FIR_CTRL_ADDR_W-1:0] reg_at(input logic [`FIR_ADDR_W-1:0] off);
    return {BASE[`FIR_CTRL_ADDR_W-1:`FIR_ADDR_W], off};
  endfunction

  function automatic void add(input op_t op, input logic [`FIR_CTRL_ADDR_W-1:0] addr,
                              input logic [31:0] data, input logic [31:0] exp_rd, input int len);
    entry_t e;
    e.op     = op;
    e.addr   = addr;
    e.data   = data;
    e.exp_rd = exp_rd;
    e.len    = 16'(len);
    stim_q.push_back(e);
  endfunction

  function automatic void build_table();
    // Identification, clean status, out of block read, read-only write
    add(OP_READ, reg_at(`REG_NUM_COEFFS), 0, N, 0);
    add(OP_READ, reg_at(`REG_STATUS), 0, 0, 0);
    add(OP_READ, BASE + 20'h00200, 0, 0, 0);
    add(OP_WRITE, reg_at(`REG_NUM_COEFFS), 32'h1234, 0, 0);
    // Impulse bank
    add(OP_BURST, 0, 0, 0, 20);
    add(OP_READ, reg_at(`REG_STATUS), 0, 32'h2, 0);
    // Full random set
    for (int k = 0; k < N - 1; k++) begin
      add(OP_WRITE, reg_at(`REG_LOAD_COEFF), $urandom, 0, 0);
    end
    add(OP_WRITE, reg_at(`REG_LOAD_COEFF_LAST), $urandom, 0, 0);
    add(OP_BURST, 0, 0, 0, 32);
    // Short load, previous bank must stay
    for (int k = 0; k < 3; k++) begin
      add(OP_WRITE, reg_at(`REG_LOAD_COEFF), $urandom, 0, 0);
    end
    add(OP_WRITE, reg_at(`REG_LOAD_COEFF_LAST), $urandom, 0, 0);
    add(OP_READ, reg_at(`REG_STATUS), 0, 32'h3, 0);
    add(OP_BURST, 0, 0, 0, 24);
  endfunction

  // --------------------------------------------------
  // Drivers
  // --------------------------------------------------
  task automatic run_ctrl(input entry_t e);
    fir_pkg::ctrl_resp_t exp;
    fir_pkg::ctrl_resp_t got;
    logic [`FIR_ADDR_W-1:0] off;
    logic in_block;
    logic is_load;
    int lat;
    off = {e.addr[`FIR_ADDR_W-1:2], 2'b00};
    in_block = (e.addr[`FIR_CTRL_ADDR_W-1:`FIR_ADDR_W] ==
                BASE[`FIR_CTRL_ADDR_W-1:`FIR_ADDR_W]);
    is_load = (e.op == OP_WRITE) &&
              (off == `REG_LOAD_COEFF || off == `REG_LOAD_COEFF_LAST);
    ctrl_req.wr   = (e.op == OP_WRITE);
    ctrl_req.rd   = (e.op == OP_READ);
    ctrl_req.addr = e.addr;
    ctrl_req.data = e.data;
    lat = 0;
    // One-cycle pulse, then count cycles to the ack
    do begin
      @(negedge clk);
      ctrl_req = '0;
      lat++;
    end while (!ctrl_resp.ack && lat < 8);
    got = ctrl_resp;
    if (!in_block) begin
      if (got.ack) begin
        stop_on_error("A request outside the block was acknowledged");
      end
    end else if (!got.ack) begin
      stop_on_error("No ack arrived within 8 cycles of the request");
    end else begin
      check_ack_delay(is_load ? 2 : 1, lat);
      if (e.op == OP_READ) begin
        exp.ack  = 1'b1;
        exp.data = e.exp_rd;
        check_resp(exp, got);
      end else begin
        model_write(off, e.data[`FIR_COEFF_W-1:0]);
      end
    end
  endtask

  task automatic run_burst(input int len);
    exp_out_t e;
    int sent;
    logic have;
    sent = 0;
    have = 1'b0;
    // Idle cycle so a just committed bank is in place
    @(negedge clk);
    while (sent < len || exp_q.size() > 0) begin
      if (sent < len && !have) begin
        s_tdata.raw = $urandom;
        s_tlast     = (sent == len - 1) || ($urandom_range(4) == 0);
        have        = 1'b1;
      end
      s_tvalid = (sent < len);
      m_tready = ($urandom_range(3) != 0);
      // Handshake signals settled well before the next rising edge
      #1;
      if (m_tvalid && m_tready) begin
        if (exp_q.size() == 0) begin
          stop_on_error("Output word appeared with no matching input sample");
        end
        e = exp_q.pop_front();
        check_sample(e.word, m_tdata);
        check_last(e.last, m_tlast);
      end
      if (s_tvalid && s_tready) begin
        model_sample(s_tdata, s_tlast);
        sent++;
        have = 1'b0;
      end
      @(negedge clk);
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    m_tready = 1'b1;
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    int samples;
    void'($urandom(55));
    rst      = 1'b1;
    ctrl_req = '0;
    s_tdata  = '0;
    s_tlast  = 1'b0;
    s_tvalid = 1'b0;
    m_tready = 1'b1;
    m_bank    = '0;
    m_bank[0] = 16'h7FFF;
    fill_cnt  = 0;
    hist_i    = '{default: '0};
    hist_q    = '{default: '0};
    build_table();
    samples = 0;
    foreach (stim_q[n]) begin
      if (stim_q[n].op == OP_BURST) begin
        samples += stim_q[n].len;
      end
    end
    limit = 40 * stim_q.size() + 20 * samples + 10;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    foreach (stim_q[n]) begin
      if (stim_q[n].op == OP_BURST) begin
        run_burst(stim_q[n].len);
      end else begin
        run_ctrl(stim_q[n]);
      end
    end
    $display("TEST PASS");
    $finish;
  end

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    stop_on_error("Watchdog expired before the stimulus table completed");
  end

endmodule

// ==== project.f ====
+incdir+.
fir_pkg.sv
fir_ctrl_regs.sv
fir_coeff_loader.sv
fir_fill_counter.sv
fir_channel.sv
fir_iq_core.sv
tb_fir_iq_core.sv

// ==== Bender.yml ====
package:
  name: fir_iq_core

sources:
  - include_dirs:
      - .
    files:
      - fir_pkg.sv
      - fir_ctrl_regs.sv
      - fir_coeff_loader.sv
      - fir_fill_counter.sv
      - fir_channel.sv
      - fir_iq_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fir_iq_core.sv
